//--- common/frame_cfg_pkg.sv
////////////////////////////////////////
// register map of the APB config block
// word addresses only, 8 bit address
// all fields reset to zero
////////////////////////////////////////

package frame_cfg_pkg;

   localparam int APB_AW = 8;

   // register select by word address
   typedef enum logic [APB_AW-1:0] {
      REG_CTRL      = 8'h00,
      REG_OSD_POS   = 8'h04,
      REG_OSD_SIZE  = 8'h08,
      REG_OSD_COLOR = 8'h0C
   } frame_reg_e;

   // CTRL bits
   localparam int CTRL_SCAN2X_DIS = 0;
   localparam int CTRL_YPBPR      = 1;
   localparam int CTRL_OSD_EN     = 2;
   localparam int CTRL_SND_SIGNED = 3;

   // beam coordinates, shared by OSD_POS and OSD_SIZE
   localparam int COORD_W = 10;
   localparam int X_LSB   = 0;
   localparam int Y_LSB   = 16;

   // OSD colour fields
   localparam int OSD_CH_W  = 6;
   localparam int OSD_R_LSB = 12;
   localparam int OSD_G_LSB = 6;
   localparam int OSD_B_LSB = 0;
   localparam int OSD_RGB_W = 3 * OSD_CH_W;

endpackage

//--- common/frame_video_pkg.sv
////////////////////////////////////////
// video and sound widths
// YPbPr weights are over 256
////////////////////////////////////////

package frame_video_pkg;

   localparam int COLORW  = 4;    // native game colour
   localparam int VIDEO_W = 6;    // board side colour
   localparam int VID_LAT = 3;    // input to VIDEO_*_o, cycles
   localparam int SND_W   = 16;

   // luma
   localparam int Y_KR = 77;
   localparam int Y_KG = 150;
   localparam int Y_KB = 29;

   // blue difference
   localparam int PB_KR = -43;
   localparam int PB_KG = -85;
   localparam int PB_KB = 128;

   // red difference
   localparam int PR_KR = 128;
   localparam int PR_KG = -107;
   localparam int PR_KB = -21;

   localparam int CHROMA_MID = 32;  // zero chroma level

endpackage

//--- design/frame_regs.sv
////////////////////////////////////////
// APB slave, no wait states
// bad address gives pslverr, write
// ignored and read returns zero
////////////////////////////////////////

`timescale 1ns/100ps

module frame_regs (
   input  logic                                 clk_sys,
   input  logic                                 rst_i,
   input  logic                                 psel_i,
   input  logic                                 penable_i,
   input  logic                                 pwrite_i,
   input  logic [frame_cfg_pkg::APB_AW-1:0]     paddr_i,
   input  logic [31:0]                          pwdata_i,
   output logic [31:0]                          prdata_o,
   output logic                                 pready_o,
   output logic                                 pslverr_o,
   output logic                                 scan2x_dis_o,
   output logic                                 ypbpr_o,
   output logic                                 osd_en_o,
   output logic                                 snd_signed_o,
   output logic [frame_cfg_pkg::COORD_W-1:0]    osd_x_o,
   output logic [frame_cfg_pkg::COORD_W-1:0]    osd_y_o,
   output logic [frame_cfg_pkg::COORD_W-1:0]    osd_w_o,
   output logic [frame_cfg_pkg::COORD_W-1:0]    osd_h_o,
   output logic [frame_cfg_pkg::OSD_RGB_W-1:0]  osd_rgb_o
);
   import frame_cfg_pkg::*;

   logic [CTRL_SND_SIGNED:0] ctrl_q;
   logic [COORD_W-1:0]       pos_x_q, pos_y_q, size_w_q, size_h_q;
   logic [OSD_RGB_W-1:0]     rgb_q;
   frame_reg_e               reg_sel;
   logic                     addr_ok;
   logic                     access;
   logic [31:0]              rd_data;

   assign access  = psel_i & penable_i;
   assign reg_sel = frame_reg_e'(paddr_i);

   // decode and read-back, unaligned addresses miss every entry
   always_comb begin
      rd_data = '0;
      addr_ok = 1'b1;
      case (reg_sel)
         REG_CTRL: rd_data[CTRL_SND_SIGNED:0] = ctrl_q;
         REG_OSD_POS: begin
            rd_data[X_LSB +: COORD_W] = pos_x_q;
            rd_data[Y_LSB +: COORD_W] = pos_y_q;
         end
         REG_OSD_SIZE: begin
            rd_data[X_LSB +: COORD_W] = size_w_q;
            rd_data[Y_LSB +: COORD_W] = size_h_q;
         end
         REG_OSD_COLOR: rd_data[OSD_RGB_W-1:0] = rgb_q;
         default: addr_ok = 1'b0;
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         ctrl_q   <= '0;
         pos_x_q  <= '0;
         pos_y_q  <= '0;
         size_w_q <= '0;
         size_h_q <= '0;
         rgb_q    <= '0;
      end else if (access && pwrite_i && addr_ok) begin
         case (reg_sel)
            REG_CTRL: ctrl_q <= pwdata_i[CTRL_SND_SIGNED:0];
            REG_OSD_POS: begin
               pos_x_q <= pwdata_i[X_LSB +: COORD_W];
               pos_y_q <= pwdata_i[Y_LSB +: COORD_W];
            end
            REG_OSD_SIZE: begin
               size_w_q <= pwdata_i[X_LSB +: COORD_W];
               size_h_q <= pwdata_i[Y_LSB +: COORD_W];
            end
            default: rgb_q <= pwdata_i[OSD_RGB_W-1:0];   // REG_OSD_COLOR
         endcase
      end
   end

   assign prdata_o  = access ? rd_data : '0;
   assign pready_o  = 1'b1;
   assign pslverr_o = access & ~addr_ok;

   assign scan2x_dis_o = ctrl_q[CTRL_SCAN2X_DIS];
   assign ypbpr_o      = ctrl_q[CTRL_YPBPR];
   assign osd_en_o     = ctrl_q[CTRL_OSD_EN];
   assign snd_signed_o = ctrl_q[CTRL_SND_SIGNED];
   assign osd_x_o      = pos_x_q;
   assign osd_y_o      = pos_y_q;
   assign osd_w_o      = size_w_q;
   assign osd_h_o      = size_h_q;
   assign osd_rgb_o    = rgb_q;

endmodule

//--- video/frame_src_sel.sv
////////////////////////////////////////
// video stage 1, stream select
// game colour widened by replication
////////////////////////////////////////

`timescale 1ns/100ps

module frame_src_sel (
   input  logic                                clk_sys,
   input  logic                                rst_i,
   input  logic                                scan2x_dis_i,
   input  logic [frame_video_pkg::COLORW-1:0]  game_r_i,
   input  logic [frame_video_pkg::COLORW-1:0]  game_g_i,
   input  logic [frame_video_pkg::COLORW-1:0]  game_b_i,
   input  logic                                game_hs_i,
   input  logic                                game_vs_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0] scan_r_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0] scan_g_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0] scan_b_i,
   input  logic                                scan_hs_i,
   input  logic                                scan_vs_i,
   output logic [frame_video_pkg::VIDEO_W-1:0] r_o,
   output logic [frame_video_pkg::VIDEO_W-1:0] g_o,
   output logic [frame_video_pkg::VIDEO_W-1:0] b_o,
   output logic                                hs_o,
   output logic                                vs_o
);
   import frame_video_pkg::*;

   // msb first, repeating from the top bit again
   function automatic logic [VIDEO_W-1:0] widen(input logic [COLORW-1:0] c);
      logic [VIDEO_W-1:0] w;
      for (int i = 0; i < VIDEO_W; i++) begin
         w[VIDEO_W-1-i] = c[COLORW-1-(i % COLORW)];
      end
      return w;
   endfunction

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         r_o  <= '0;
         g_o  <= '0;
         b_o  <= '0;
         hs_o <= 1'b0;
         vs_o <= 1'b0;
      end else if (scan2x_dis_i) begin   // native 15 kHz
         r_o  <= widen(game_r_i);
         g_o  <= widen(game_g_i);
         b_o  <= widen(game_b_i);
         hs_o <= game_hs_i;
         vs_o <= game_vs_i;
      end else begin
         r_o  <= scan_r_i;
         g_o  <= scan_g_i;
         b_o  <= scan_b_i;
         hs_o <= scan_hs_i;
         vs_o <= scan_vs_i;
      end
   end

endmodule

//--- video/frame_osd.sv
////////////////////////////////////////
// video stage 2, OSD window blend
// counters follow hs and vs high pulses
// blend is c/2 + osd/2, truncated
////////////////////////////////////////

`timescale 1ns/100ps

module frame_osd (
   input  logic                                  clk_sys,
   input  logic                                  rst_i,
   input  logic                                  osd_en_i,
   input  logic [frame_cfg_pkg::COORD_W-1:0]     osd_x_i,
   input  logic [frame_cfg_pkg::COORD_W-1:0]     osd_y_i,
   input  logic [frame_cfg_pkg::COORD_W-1:0]     osd_w_i,
   input  logic [frame_cfg_pkg::COORD_W-1:0]     osd_h_i,
   input  logic [frame_cfg_pkg::OSD_RGB_W-1:0]   osd_rgb_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0]   r_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0]   g_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0]   b_i,
   input  logic                                  hs_i,
   input  logic                                  vs_i,
   output logic [frame_video_pkg::VIDEO_W-1:0]   r_o,
   output logic [frame_video_pkg::VIDEO_W-1:0]   g_o,
   output logic [frame_video_pkg::VIDEO_W-1:0]   b_o,
   output logic                                  hs_o,
   output logic                                  vs_o
);
   import frame_cfg_pkg::*;
   import frame_video_pkg::*;

   logic [COORD_W-1:0] h_q, v_q;
   logic [COORD_W-1:0] h_cur, v_cur;
   logic               hs_rise;
   logic               in_win;

   function automatic logic [VIDEO_W-1:0] blend(input logic [VIDEO_W-1:0] c,
                                                input logic [OSD_CH_W-1:0] o);
      return (c >> 1) + (o >> 1);
   endfunction

   assign hs_rise = hs_i & ~hs_o;     // hs_o holds last cycle's hs
   assign h_cur   = hs_i ? '0 : h_q + 1'b1;
   assign v_cur   = vs_i ? '0 : (hs_rise ? v_q + 1'b1 : v_q);

   // end of window one bit wider, no wrap
   assign in_win = osd_en_i &&
                   ({1'b0, h_cur} >= {1'b0, osd_x_i}) &&
                   ({1'b0, h_cur} <  {1'b0, osd_x_i} + {1'b0, osd_w_i}) &&
                   ({1'b0, v_cur} >= {1'b0, osd_y_i}) &&
                   ({1'b0, v_cur} <  {1'b0, osd_y_i} + {1'b0, osd_h_i});

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         h_q  <= '0;
         v_q  <= '0;
         r_o  <= '0;
         g_o  <= '0;
         b_o  <= '0;
         hs_o <= 1'b0;
         vs_o <= 1'b0;
      end else begin
         h_q  <= h_cur;
         v_q  <= v_cur;
         hs_o <= hs_i;
         vs_o <= vs_i;
         if (in_win) begin
            r_o <= blend(r_i, osd_rgb_i[OSD_R_LSB +: OSD_CH_W]);
            g_o <= blend(g_i, osd_rgb_i[OSD_G_LSB +: OSD_CH_W]);
            b_o <= blend(b_i, osd_rgb_i[OSD_B_LSB +: OSD_CH_W]);
         end else begin
            r_o <= r_i;
            g_o <= g_i;
            b_o <= b_i;
         end
      end
   end

endmodule

//--- video/frame_ypbpr_out.sv
////////////////////////////////////////
// video stage 3, board outputs
// composite sync on hs, vs high, in
// 15 kHz or YPbPr mode
////////////////////////////////////////

`timescale 1ns/100ps

module frame_ypbpr_out (
   input  logic                                clk_sys,
   input  logic                                rst_i,
   input  logic                                ypbpr_i,
   input  logic                                scan2x_dis_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0] r_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0] g_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0] b_i,
   input  logic                                hs_i,
   input  logic                                vs_i,
   output logic [frame_video_pkg::VIDEO_W-1:0] video_r_o,
   output logic [frame_video_pkg::VIDEO_W-1:0] video_g_o,
   output logic [frame_video_pkg::VIDEO_W-1:0] video_b_o,
   output logic                                video_hs_o,
   output logic                                video_vs_o
);
   import frame_video_pkg::*;

   int r_v, g_v, b_v;
   int y_v, pb_v, pr_v;
   logic csync_mode;

   function automatic logic [VIDEO_W-1:0] clamp(input int v);
      if (v < 0) return '0;
      if (v > (1 << VIDEO_W) - 1) return '1;
      return v[VIDEO_W-1:0];
   endfunction

   always_comb begin
      r_v  = int'(r_i);
      g_v  = int'(g_i);
      b_v  = int'(b_i);
      y_v  = (Y_KR * r_v + Y_KG * g_v + Y_KB * b_v) >>> 8;
      pb_v = CHROMA_MID + ((PB_KR * r_v + PB_KG * g_v + PB_KB * b_v) >>> 8);
      pr_v = CHROMA_MID + ((PR_KR * r_v + PR_KG * g_v + PR_KB * b_v) >>> 8);
   end

   assign csync_mode = scan2x_dis_i | ypbpr_i;

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         video_r_o  <= '0;
         video_g_o  <= '0;
         video_b_o  <= '0;
         video_hs_o <= 1'b0;
         video_vs_o <= 1'b0;
      end else begin
         video_r_o  <= ypbpr_i ? clamp(pr_v) : r_i;
         video_g_o  <= ypbpr_i ? clamp(y_v)  : g_i;
         video_b_o  <= ypbpr_i ? clamp(pb_v) : b_i;
         video_hs_o <= csync_mode ? ~(hs_i ^ vs_i) : hs_i;
         video_vs_o <= csync_mode | vs_i;   // high selects RGB on a SCART cable
      end
   end

endmodule

//--- audio/frame_sd_dac.sv
////////////////////////////////////////
// first order sigma-delta, 1 bit out
// ones per 2^16 cycles equal the
// offset binary sample
////////////////////////////////////////

`timescale 1ns/100ps

module frame_sd_dac (
   input  logic                              clk_sys,
   input  logic                              rst_i,
   input  logic                              snd_signed_i,
   input  logic [frame_video_pkg::SND_W-1:0] pcm_i,
   output logic                              dac_o
);
   import frame_video_pkg::*;

   logic [SND_W-1:0] pcm_ob;
   logic [SND_W:0]   acc_q;    // top bit is the carry of the last add

   // two's complement to offset binary
   assign pcm_ob = {pcm_i[SND_W-1] ^ snd_signed_i, pcm_i[SND_W-2:0]};

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         acc_q <= '0;
      end else begin
         acc_q <= {1'b0, acc_q[SND_W-1:0]} + {1'b0, pcm_ob};
      end
   end

   assign dac_o = acc_q[SND_W];

endmodule

//--- design/frame_base.sv
////////////////////////////////////////
// video and sound frame top, one clock
// video latency is VID_LAT cycles
////////////////////////////////////////

`timescale 1ns/100ps

module frame_base (
   input  logic                                clk_sys,
   input  logic                                rst_i,
   // APB config
   input  logic                                psel_i,
   input  logic                                penable_i,
   input  logic                                pwrite_i,
   input  logic [frame_cfg_pkg::APB_AW-1:0]    paddr_i,
   input  logic [31:0]                         pwdata_i,
   output logic [31:0]                         prdata_o,
   output logic                                pready_o,
   output logic                                pslverr_o,
   // native game video
   input  logic [frame_video_pkg::COLORW-1:0]  game_r_i,
   input  logic [frame_video_pkg::COLORW-1:0]  game_g_i,
   input  logic [frame_video_pkg::COLORW-1:0]  game_b_i,
   input  logic                                game_hs_i,
   input  logic                                game_vs_i,
   // scan doubled video
   input  logic [frame_video_pkg::VIDEO_W-1:0] scan_r_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0] scan_g_i,
   input  logic [frame_video_pkg::VIDEO_W-1:0] scan_b_i,
   input  logic                                scan_hs_i,
   input  logic                                scan_vs_i,
   input  logic [frame_video_pkg::SND_W-1:0]   snd_left_i,
   input  logic [frame_video_pkg::SND_W-1:0]   snd_right_i,
   output logic [frame_video_pkg::VIDEO_W-1:0] video_r_o,
   output logic [frame_video_pkg::VIDEO_W-1:0] video_g_o,
   output logic [frame_video_pkg::VIDEO_W-1:0] video_b_o,
   output logic                                video_hs_o,
   output logic                                video_vs_o,
   output logic                                snd_pwm_left_o,
   output logic                                snd_pwm_right_o
);
   import frame_cfg_pkg::*;
   import frame_video_pkg::*;

   logic                 scan2x_dis, ypbpr, osd_en, snd_signed;
   logic [COORD_W-1:0]   osd_x, osd_y, osd_w, osd_h;
   logic [OSD_RGB_W-1:0] osd_rgb;
   logic [VIDEO_W-1:0]   s1_r, s1_g, s1_b, s2_r, s2_g, s2_b;
   logic                 s1_hs, s1_vs, s2_hs, s2_vs;

   frame_regs u_regs (
      .clk_sys, .rst_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
      .prdata_o, .pready_o, .pslverr_o,
      .scan2x_dis_o (scan2x_dis), .ypbpr_o (ypbpr),
      .osd_en_o     (osd_en),     .snd_signed_o (snd_signed),
      .osd_x_o      (osd_x),      .osd_y_o (osd_y),
      .osd_w_o      (osd_w),      .osd_h_o (osd_h),
      .osd_rgb_o    (osd_rgb)
   );

   frame_src_sel u_src_sel (
      .clk_sys, .rst_i, .scan2x_dis_i (scan2x_dis),
      .game_r_i, .game_g_i, .game_b_i, .game_hs_i, .game_vs_i,
      .scan_r_i, .scan_g_i, .scan_b_i, .scan_hs_i, .scan_vs_i,
      .r_o (s1_r), .g_o (s1_g), .b_o (s1_b), .hs_o (s1_hs), .vs_o (s1_vs)
   );

   frame_osd u_osd (
      .clk_sys, .rst_i, .osd_en_i (osd_en),
      .osd_x_i (osd_x), .osd_y_i (osd_y), .osd_w_i (osd_w), .osd_h_i (osd_h),
      .osd_rgb_i (osd_rgb),
      .r_i (s1_r), .g_i (s1_g), .b_i (s1_b), .hs_i (s1_hs), .vs_i (s1_vs),
      .r_o (s2_r), .g_o (s2_g), .b_o (s2_b), .hs_o (s2_hs), .vs_o (s2_vs)
   );

   frame_ypbpr_out u_out (
      .clk_sys, .rst_i, .ypbpr_i (ypbpr), .scan2x_dis_i (scan2x_dis),
      .r_i (s2_r), .g_i (s2_g), .b_i (s2_b), .hs_i (s2_hs), .vs_i (s2_vs),
      .video_r_o, .video_g_o, .video_b_o, .video_hs_o, .video_vs_o
   );

   frame_sd_dac u_dac_left (
      .clk_sys, .rst_i, .snd_signed_i (snd_signed),
      .pcm_i (snd_left_i), .dac_o (snd_pwm_left_o)
   );

   frame_sd_dac u_dac_right (
      .clk_sys, .rst_i, .snd_signed_i (snd_signed),
      .pcm_i (snd_right_i), .dac_o (snd_pwm_right_o)
   );

endmodule

//--- sim/frame_base_chk.sv
////////////////////////////////////////
// protocol and sync checks, bound
// into frame_base
////////////////////////////////////////

`timescale 1ns/100ps

module frame_base_chk (
   input logic clk_sys,
   input logic rst_i,
   input logic psel_i,
   input logic penable_i,
   input logic pready_i,
   input logic pslverr_i,
   input logic ypbpr_i,
   input logic scan2x_dis_i,
   input logic video_vs_i
);
   import frame_video_pkg::*;

   int fail_cnt = 0;    // read by the testbench at the end

   a_pready: assert property (@(posedge clk_sys) disable iff (rst_i) pready_i)
      else begin
         fail_cnt++;
         $error("pready went low outside reset");
      end

   a_slverr: assert property (@(posedge clk_sys) disable iff (rst_i)
                              pslverr_i |-> psel_i && penable_i)
      else begin
         fail_cnt++;
         $error("pslverr raised outside an APB access cycle");
      end

   // csync modes keep vs high once the pipeline has settled
   a_vs_high: assert property (@(posedge clk_sys) disable iff (rst_i)
                               (ypbpr_i || scan2x_dis_i) [*VID_LAT] |=> video_vs_i)
      else begin
         fail_cnt++;
         $error("video vs low in YPbPr or 15 kHz mode");
      end

endmodule

bind frame_base frame_base_chk u_chk (
   .clk_sys,
   .rst_i,
   .psel_i,
   .penable_i,
   .pready_i     (pready_o),
   .pslverr_i    (pslverr_o),
   .ypbpr_i      (ypbpr),
   .scan2x_dis_i (scan2x_dis),
   .video_vs_i   (video_vs_o)
);

//--- sim/frame_base_tb.sv
////////////////////////////////////////
// testbench for frame_base on one clock
// raster is 16 pixels per line, hs for
// 2 pixels, vs for the first line
////////////////////////////////////////

`timescale 1ns/100ps

module frame_base_tb;
   import frame_cfg_pkg::*;
   import frame_video_pkg::*;

   localparam int N_PIX    = 64;
   localparam int LINE_LEN = 16;
   localparam int N_ENT    = 5;
   localparam int APB_TMO  = 16;    // cycles to wait for pready
   localparam int SD_WIN   = 65536;
   localparam int E_APB    = 0;
   localparam int E_VID    = 1;
   localparam int E_SND    = 2;
   localparam int E_TMO    = 3;

   logic                clk_sys = 1'b0;
   logic                rst_i;
   logic                psel, penable, pwrite, pready, pslverr;
   logic [APB_AW-1:0]   paddr;
   logic [31:0]         pwdata, prdata;
   logic [COLORW-1:0]   game_r, game_g, game_b;
   logic [VIDEO_W-1:0]  scan_r, scan_g, scan_b;
   logic                game_hs, game_vs, scan_hs, scan_vs;
   logic [SND_W-1:0]    snd_l, snd_r;
   logic [VIDEO_W-1:0]  vid_r, vid_g, vid_b;
   logic                vid_hs, vid_vs, dac_l, dac_r;

   int          err_cnt [4] = '{default: 0};
   logic [31:0] rng_state = 32'd27025;
   int          h_m, v_m;             // model beam counters
   logic        hs_prev_m = 1'b0;
   logic [19:0] expq [$];             // {r, g, b, hs, vs} per pixel

   // ctrl, osd pos, osd size, osd colour, pattern, left, right, count dac ones
   logic [31:0] tab [N_ENT][8] = '{
      '{32'h0, 32'h0,        32'h0,        32'h0,        0, 32'h1234, 32'hC000, 1},
      '{32'h4, 32'h0001_0003, 32'h0002_0006, 32'h0003_F16A, 0, 32'h0,    32'h0,    0},
      '{32'h5, 32'h0000_0005, 32'h0003_0004, 32'h0000_0FC0, 0, 32'h0,    32'h0,    0},
      '{32'h2, 32'h0,        32'h0005_0010, 32'h0003_FFFF, 1, 32'h0,    32'h0,    0},
      '{32'hF, 32'h0002_0000, 32'h0001_0010, 32'h0003_FFFF, 0, 32'h8001, 32'h7FFF, 1}
   };

   frame_base UUT (
      .clk_sys, .rst_i,
      .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
      .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
      .game_r_i (game_r), .game_g_i (game_g), .game_b_i (game_b),
      .game_hs_i (game_hs), .game_vs_i (game_vs),
      .scan_r_i (scan_r), .scan_g_i (scan_g), .scan_b_i (scan_b),
      .scan_hs_i (scan_hs), .scan_vs_i (scan_vs),
      .snd_left_i (snd_l), .snd_right_i (snd_r),
      .video_r_o (vid_r), .video_g_o (vid_g), .video_b_o (vid_b),
      .video_hs_o (vid_hs), .video_vs_o (vid_vs),
      .snd_pwm_left_o (dac_l), .snd_pwm_right_o (dac_r)
   );

   always #20 clk_sys = ~clk_sys;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   // 4 bit colour then its top two bits
   function automatic logic [VIDEO_W-1:0] widen_ref(input logic [COLORW-1:0] c);
      return {c, c[COLORW-1 -: VIDEO_W-COLORW]};
   endfunction

   function automatic int clamp6(input int x);
      return (x < 0) ? 0 : ((x > 63) ? 63 : x);
   endfunction

   // expected board output for one selected pixel
   // also steps the beam model
   function automatic logic [19:0] expect_pixel(input logic [31:0] ctrl, pos, size, col,
                                                input logic [VIDEO_W-1:0] r, g, b,
                                                input logic hs, vs);
      int   h, v, ri, gi, bi;
      logic in_win, cs, hs_e, vs_e;
      logic [VIDEO_W-1:0] o_r, o_g, o_b;
      h = hs ? 0 : h_m + 1;
      v = vs ? 0 : ((hs && !hs_prev_m) ? v_m + 1 : v_m);
      h_m = h;
      v_m = v;
      hs_prev_m = hs;
      in_win = ctrl[CTRL_OSD_EN] && h >= pos[9:0] && h < pos[9:0] + size[9:0] &&
               v >= pos[25:16] && v < pos[25:16] + size[25:16];
      if (in_win) begin
         r = r / 2 + col[17:12] / 2;
         g = g / 2 + col[11:6] / 2;
         b = b / 2 + col[5:0] / 2;
      end
      ri = r;
      gi = g;
      bi = b;
      if (ctrl[CTRL_YPBPR]) begin
         o_g = clamp6((77 * ri + 150 * gi + 29 * bi) >>> 8);
         o_b = clamp6(32 + ((-43 * ri - 85 * gi + 128 * bi) >>> 8));
         o_r = clamp6(32 + ((128 * ri - 107 * gi - 21 * bi) >>> 8));
      end else begin
         o_r = r;
         o_g = g;
         o_b = b;
      end
      cs   = ctrl[CTRL_SCAN2X_DIS] | ctrl[CTRL_YPBPR];
      hs_e = cs ? ~(hs ^ vs) : hs;
      vs_e = cs ? 1'b1 : vs;
      return {o_r, o_g, o_b, hs_e, vs_e};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp, input int cat);
      assert (got === exp) else begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
         err_cnt[cat]++;
      end
   endtask

   task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                           input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int t;
      @(posedge clk_sys);
      psel    <= 1'b1;      // setup cycle
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk_sys);
      penable <= 1'b1;
      t = 0;
      @(negedge clk_sys);
      while (!pready && t < APB_TMO) begin
         @(negedge clk_sys);
         t++;
      end
      if (!pready) begin
         $display("APB transfer to 0x%0h got no pready within %0d cycles", addr, APB_TMO);
         err_cnt[E_TMO]++;
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk_sys);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic read_expect(input logic [APB_AW-1:0] addr, input logic [31:0] exp,
                              input logic exp_err);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b0, addr, 32'h0, rd, err);
      check_val("prdata_o", rd, exp, E_APB);
      check_val("pslverr_o", err, exp_err, E_APB);
   endtask

   task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, addr, data, rd, err);
      check_val("pslverr_o", err, 1'b0, E_APB);
      read_expect(addr, data, 1'b0);
   endtask

   initial begin
      logic [APB_AW-1:0] reg_addr [4];
      logic [31:0] rnd, rd, exp, c;
      logic [COLORW-1:0]  gr, gg, gb;
      logic [VIDEO_W-1:0] sr, sg, sb;
      logic        hs, vs, err, dis;
      int          cnt_l, cnt_r;
      reg_addr = '{REG_CTRL, REG_OSD_POS, REG_OSD_SIZE, REG_OSD_COLOR};
      rst_i   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      {game_r, game_g, game_b, game_hs, game_vs} = '0;
      {scan_r, scan_g, scan_b, scan_hs, scan_vs} = '0;
      snd_l   = '0;
      snd_r   = '0;
      repeat (2) @(posedge clk_sys);
      rst_i <= 1'b0;
      for (int k = 0; k < VID_LAT; k++) begin
         @(negedge clk_sys);
         check_val("video outputs", {vid_r, vid_g, vid_b, vid_hs, vid_vs}, 32'h0, E_VID);
         check_val("dac outputs", {dac_l, dac_r}, 32'h0, E_SND);
      end

      // reset values and bad addresses
      foreach (reg_addr[k]) read_expect(reg_addr[k], 32'h0, 1'b0);
      apb_xfer(1'b1, 8'h10, 32'hFFFF_FFFF, rd, err);
      check_val("pslverr_o", err, 1'b1, E_APB);
      apb_xfer(1'b1, 8'h01, 32'hFFFF_FFFF, rd, err);
      check_val("pslverr_o", err, 1'b1, E_APB);
      read_expect(8'h10, 32'h0, 1'b1);
      read_expect(8'h01, 32'h0, 1'b1);
      foreach (reg_addr[k]) read_expect(reg_addr[k], 32'h0, 1'b0);

      for (int e = 0; e < N_ENT; e++) begin
         @(posedge clk_sys);
         snd_l <= tab[e][5][SND_W-1:0];
         snd_r <= tab[e][6][SND_W-1:0];
         write_reg(REG_OSD_POS, tab[e][1]);
         write_reg(REG_OSD_SIZE, tab[e][2]);
         write_reg(REG_OSD_COLOR, tab[e][3]);
         write_reg(REG_CTRL, tab[e][0]);
         dis = tab[e][0][CTRL_SCAN2X_DIS];
         expq.delete();
         for (int i = 0; i < N_PIX + VID_LAT; i++) begin
            hs = (i % LINE_LEN) < 2;
            vs = (i / LINE_LEN) == 0;
            if (tab[e][4] == 0) begin
               rnd = next_rand();
               {gr, gg, gb} = rnd[31:20];
               rnd = next_rand();
               {sr, sg, sb} = rnd[31:14];
            end else begin       // corner colours of the cube
               {gr, gg, gb} = {{COLORW{i[0]}}, {COLORW{i[1]}}, {COLORW{i[2]}}};
               {sr, sg, sb} = {{VIDEO_W{i[0]}}, {VIDEO_W{i[1]}}, {VIDEO_W{i[2]}}};
            end
            @(posedge clk_sys);
            // unselected stream carries inverted syncs
            {game_r, game_g, game_b, game_hs, game_vs} <= {gr, gg, gb, hs ^ ~dis, vs ^ ~dis};
            {scan_r, scan_g, scan_b, scan_hs, scan_vs} <= {sr, sg, sb, hs ^ dis, vs ^ dis};
            expq.push_back(expect_pixel(tab[e][0], tab[e][1], tab[e][2], tab[e][3],
                                        dis ? widen_ref(gr) : sr,
                                        dis ? widen_ref(gg) : sg,
                                        dis ? widen_ref(gb) : sb, hs, vs));
            @(negedge clk_sys);
            if (expq.size() > VID_LAT) begin
               exp = expq.pop_front();
               check_val("video_r_o", vid_r, exp[19:14], E_VID);
               check_val("video_g_o", vid_g, exp[13:8], E_VID);
               check_val("video_b_o", vid_b, exp[7:2], E_VID);
               check_val("video_hs_o", vid_hs, exp[1], E_VID);
               check_val("video_vs_o", vid_vs, exp[0], E_VID);
            end
         end
         if (tab[e][7] != 0) begin
            cnt_l = 0;
            cnt_r = 0;
            for (int k = 0; k < SD_WIN; k++) begin
               @(negedge clk_sys);
               cnt_l += dac_l;
               cnt_r += dac_r;
            end
            c = tab[e][0][CTRL_SND_SIGNED] ? 32'h8000 : 32'h0;   // offset binary flip
            check_val("snd_pwm_left_o ones", cnt_l, (tab[e][5] ^ c) & 32'hFFFF, E_SND);
            check_val("snd_pwm_right_o ones", cnt_r, (tab[e][6] ^ c) & 32'hFFFF, E_SND);
         end
      end

      $display("errors: apb %0d, video %0d, sound %0d, timeout %0d, assertion %0d",
               err_cnt[E_APB], err_cnt[E_VID], err_cnt[E_SND], err_cnt[E_TMO],
               UUT.u_chk.fail_cnt);
      if (err_cnt.sum() + UUT.u_chk.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- tb.f
common/frame_cfg_pkg.sv
common/frame_video_pkg.sv
design/frame_regs.sv
video/frame_src_sel.sv
video/frame_osd.sv
video/frame_ypbpr_out.sv
audio/frame_sd_dac.sv
design/frame_base.sv
sim/frame_base_chk.sv
sim/frame_base_tb.sv

//--- Bender.yml
package:
  name: frame_base

sources:
  - common/frame_cfg_pkg.sv
  - common/frame_video_pkg.sv
  - design/frame_regs.sv
  - video/frame_src_sel.sv
  - video/frame_osd.sv
  - video/frame_ypbpr_out.sv
  - audio/frame_sd_dac.sv
  - design/frame_base.sv
  - target: simulation
    files:
      - sim/frame_base_chk.sv
      - sim/frame_base_tb.sv
